/* compile.f */
+incdir+include
source/display_pkg.sv
source/stream_buffer.sv
source/serial_shifter.sv
source/display_sequencer.sv
source/serial_display_top.sv
dv/tb_serial_display.sv

/* dv/tb_serial_display.sv */
/*
 * directed testbench for serial_display_top, two frames after the init table
 * serial bytes are rebuilt from the line at each rising out_sclk
 * out_frame_done marks word buffer acceptance, so it precedes the last serial byte
 */
`include "display_macros.svh"

module tb_serial_display
	import display_pkg::*;
();

	localparam int FRAME_PIX       = `DISP_SCREEN_WIDTH * `DISP_SCREEN_HEIGHT;
	localparam int FRAME_BYTES     = 2 * FRAME_PIX;
	localparam int BYTE_CYCLES     = 2 * `DISP_SERIAL_BITS * `DISP_CLK_DIV;
	localparam int WATCHDOG_CYCLES = 2 * (2 * FRAME_BYTES * BYTE_CYCLES
		+ `DISP_INIT_BYTES * BYTE_CYCLES + `DISP_RST_CYCLES + 8);

	logic   in_clk;
	logic   in_rst;
	logic   in_pix_valid;
	logic   in_pix_ready;
	pixel_t in_pix;
	logic   out_disp_rst;
	logic   out_sclk;
	logic   out_sdata;
	logic   out_dc;
	logic   out_frame_done;

	integer seed = 32'h0fd08ee2;
	logic   saw_stall;

	// serial line monitor state
	serial_word_t                 byte_q [$];
	logic                         prev_sclk = 1'b1;
	logic [`DISP_SERIAL_BITS-1:0] shift_byte = '0;
	int                           bit_cnt = 0;
	int                           data_bytes = 0;
	int                           pulse_count = 0;
	int                           frames_seen = 0;
	int                           pulses_at_frame [2];

	serial_display_top dut (
		.in_clk         (in_clk),
		.in_rst         (in_rst),
		.in_pix_valid   (in_pix_valid),
		.in_pix_ready   (in_pix_ready),
		.in_pix         (in_pix),
		.out_disp_rst   (out_disp_rst),
		.out_sclk       (out_sclk),
		.out_sdata      (out_sdata),
		.out_dc         (out_dc),
		.out_frame_done (out_frame_done)
	);

	initial begin
		in_clk = 1'b0;
		forever #10 in_clk = ~in_clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge in_clk);
		$display("timeout, the serial line did not deliver all frames within %0d cycles",
			WATCHDOG_CYCLES);
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

	// ------------------------------------------------------------
	// monitor, outputs are settled at the falling clock edge
	// ------------------------------------------------------------
	always @(negedge in_clk) begin
		if (!in_rst) begin
			if (out_frame_done) begin
				pulse_count++;
			end
			if (out_sclk && !prev_sclk) begin
				shift_byte = {shift_byte[`DISP_SERIAL_BITS-2:0], out_sdata};
				bit_cnt++;
				if (bit_cnt == `DISP_SERIAL_BITS) begin
					byte_q.push_back({out_dc, shift_byte});
					bit_cnt = 0;
					if (out_dc) begin
						data_bytes++;
						// frame fully on the wire
						if (data_bytes % FRAME_BYTES == 0 && frames_seen < 2) begin
							pulses_at_frame[frames_seen] = pulse_count;
							frames_seen++;
						end
					end
				end
			end
		end
		prev_sclk = out_sclk;
	end

	task automatic check_equal(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error %s: expected %h, actual %h", test_name, expected, actual);
			$display("sim failed");
			$fatal(1, "mismatch in %s", test_name);
		end
	endtask

	// call at a falling edge, returns at the falling edge after the transfer
	task automatic send_pixel(input pixel_t p);
		logic taken;
		taken        = 1'b0;
		in_pix_valid = 1'b1;
		in_pix       = p;
		while (!taken) begin
			taken = in_pix_ready;
			if (!in_pix_ready) begin
				saw_stall = 1'b1;
			end
			@(negedge in_clk);
		end
		in_pix_valid = 1'b0;
	endtask

	task automatic wait_bytes(input int n);
		while (byte_q.size() < n) begin
			@(negedge in_clk);
		end
	endtask

	// each pixel is a high byte then a low byte, both as data
	task automatic check_pixels(input string test_name, ref pixel_t expected [$]);
		serial_word_t got;
		pixel_t       p;
		while (expected.size() > 0) begin
			p = expected.pop_front();
			wait_bytes(2);
			got = byte_q.pop_front();
			check_equal(test_name, {1'b1, p[15:8]}, got);
			got = byte_q.pop_front();
			check_equal(test_name, {1'b1, p[7:0]}, got);
		end
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic test_reset_state();
		int cycles;
		cycles = 0;
		check_equal("test_reset_state", 1, out_sclk);
		check_equal("test_reset_state", 0, out_sdata);
		check_equal("test_reset_state", 0, out_frame_done);
		check_equal("test_reset_state", 1, out_disp_rst);
		while (out_disp_rst) begin
			cycles++;
			@(negedge in_clk);
		end
		check_equal("test_reset_state", `DISP_RST_CYCLES, cycles);
	endtask

	task automatic test_init_bytes();
		serial_word_t got;
		wait_bytes(`DISP_INIT_BYTES);
		for (int i = 0; i < `DISP_INIT_BYTES; i++) begin
			got = byte_q.pop_front();
			check_equal("test_init_bytes", {1'b0, init_cmds[i]}, got);
		end
	endtask

	task automatic test_frame_pixels();
		pixel_t expected [$];
		pixel_t p;
		for (int i = 0; i < FRAME_PIX; i++) begin
			p = pixel_t'(16'h1000 + i * 16'h0101);
			expected.push_back(p);
			send_pixel(p);
		end
		check_pixels("test_frame_pixels", expected);
	endtask

	task automatic test_backpressure();
		pixel_t expected [$];
		pixel_t p;
		int     gap;
		saw_stall = 1'b0;
		for (int i = 0; i < FRAME_PIX; i++) begin
			p   = pixel_t'($random(seed));
			gap = {$random(seed)} % 4;
			expected.push_back(p);
			send_pixel(p);
			repeat (gap) @(negedge in_clk);
		end
		check_equal("test_backpressure", 1, saw_stall);
		check_pixels("test_backpressure", expected);
		// line must stay quiet, no init bytes come back
		repeat (2 * BYTE_CYCLES) @(negedge in_clk);
		check_equal("test_backpressure", 0, byte_q.size());
	endtask

	task automatic test_frame_done();
		while (frames_seen < 2) begin
			@(negedge in_clk);
		end
		check_equal("test_frame_done", 1, pulses_at_frame[0]);
		check_equal("test_frame_done", 2, pulses_at_frame[1]);
		check_equal("test_frame_done", 2, pulse_count);
	endtask

	initial begin
		in_rst       = 1'b1;
		in_pix_valid = 1'b0;
		in_pix       = '0;
		saw_stall    = 1'b0;
		repeat (8) @(negedge in_clk);
		in_rst = 1'b0;
		test_reset_state();
		test_init_bytes();
		test_frame_pixels();
		test_backpressure();
		test_frame_done();
		$display("sim passed");
		$finish;
	end

endmodule

/* include/display_macros.svh */
/*
 * sizes and timing shared by the serial display controller
 * DISP_PIXEL_BITS must be twice DISP_SERIAL_BITS, one pixel goes out as two words
 */
`ifndef DISPLAY_MACROS_SVH
`define DISPLAY_MACROS_SVH

// ------------------------------------------------------------
// screen geometry
// ------------------------------------------------------------
`define DISP_SCREEN_WIDTH  8
`define DISP_SCREEN_HEIGHT 4

// pixel and serial word widths
`define DISP_PIXEL_BITS    16
`define DISP_SERIAL_BITS   8

// ------------------------------------------------------------
// timing
// ------------------------------------------------------------
// main clock cycles per half period of the serial clock
`define DISP_CLK_DIV       4
// panel reset pulse length in main clock cycles
`define DISP_RST_CYCLES    16

// number of command bytes sent once after the reset pulse
`define DISP_INIT_BYTES    4

// default buffer depth
`define DISP_FIFO_DEPTH    4

`endif

/* run_sim.sh */
#!/bin/sh
# build and run the serial display testbench with Verilator
# exit status is 0 only when the run prints the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f --top-module tb_serial_display \
	--Mdir obj_dir -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -F "sim passed" > /dev/null \
	&& exit 0 \
	|| exit 1

/* source/display_pkg.sv */
/*
 * types shared by the display controller and its testbench
 * init_cmds must hold exactly DISP_INIT_BYTES entries, element 0 goes out first
 */
`include "display_macros.svh"

package display_pkg;

	// one pixel as delivered by the upstream stream
	typedef logic [`DISP_PIXEL_BITS-1:0] pixel_t;

	// one byte for the serial line
	// dc is 1 for pixel data, 0 for a command
	typedef struct packed {
		logic                         dc;
		logic [`DISP_SERIAL_BITS-1:0] data;
	} serial_word_t;

	// command table, index 0 is the leftmost entry
	typedef logic [0:`DISP_INIT_BYTES-1][`DISP_SERIAL_BITS-1:0] init_table_t;

	// display off, remap, normal display, display on
	localparam init_table_t init_cmds = '{
		8'hae,
		8'ha0,
		8'ha4,
		8'haf
	};

endpackage

/* source/display_sequencer.sv */
/*
 * panel reset pulse, then the init table once, then pixels forever
 * a pixel is taken only together with its high byte, the low byte follows
 * no pixel coordinates go out, only a one cycle end of frame pulse
 */
`include "display_macros.svh"

module display_sequencer
	import display_pkg::*;
(
	input  logic         in_clk,
	input  logic         in_rst,

	// pixel stream in
	input  logic         in_pix_valid,
	output logic         in_pix_ready,
	input  pixel_t       in_pix,

	// word stream out
	output logic         out_word_valid,
	input  logic         in_word_ready,
	output serial_word_t out_word,

	// panel control
	output logic         out_disp_rst,
	output logic         out_frame_done
);

	localparam int RST_W  = (`DISP_RST_CYCLES > 1) ? $clog2(`DISP_RST_CYCLES) : 1;
	localparam int INIT_W = (`DISP_INIT_BYTES > 1) ? $clog2(`DISP_INIT_BYTES) : 1;
	localparam int COL_W  = $clog2(`DISP_SCREEN_WIDTH + 1);
	localparam int ROW_W  = $clog2(`DISP_SCREEN_HEIGHT + 1);

	typedef enum logic [1:0] {
		PanelReset,
		SendInit,
		SendHigh,
		SendLow
	} state_t;

	state_t                       state;
	logic [RST_W-1:0]             rst_cnt;
	logic [INIT_W-1:0]            init_idx;
	logic [COL_W-1:0]             col;
	logic [ROW_W-1:0]             row;
	logic [`DISP_SERIAL_BITS-1:0] low_byte;
	logic                         word_take;
	logic                         last_col;
	logic                         last_row;

	assign word_take    = out_word_valid && in_word_ready;
	assign last_col     = (col == COL_W'(`DISP_SCREEN_WIDTH - 1));
	assign last_row     = (row == ROW_W'(`DISP_SCREEN_HEIGHT - 1));
	assign out_disp_rst = (state == PanelReset);

	// ------------------------------------------------------------
	// word offer
	// ------------------------------------------------------------
	always_comb begin
		out_word_valid = 1'b0;
		in_pix_ready   = 1'b0;
		out_word       = '0;
		case (state)
			SendInit: begin
				out_word_valid = 1'b1;
				out_word.dc    = 1'b0;
				out_word.data  = init_cmds[init_idx];
			end
			SendHigh: begin
				// pixel and high byte move together
				out_word_valid = in_pix_valid;
				in_pix_ready   = in_word_ready;
				out_word.dc    = 1'b1;
				out_word.data  = in_pix[`DISP_PIXEL_BITS-1 -: `DISP_SERIAL_BITS];
			end
			SendLow: begin
				out_word_valid = 1'b1;
				out_word.dc    = 1'b1;
				out_word.data  = low_byte;
			end
			default: begin
			end
		endcase
	end

	// low byte waits here while the high byte goes out
	always_ff @(posedge in_clk) begin
		if (state == SendHigh && word_take) begin
			low_byte <= in_pix[`DISP_SERIAL_BITS-1:0];
		end
	end

	// ------------------------------------------------------------
	// state and counters
	// ------------------------------------------------------------
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			state          <= PanelReset;
			rst_cnt        <= '0;
			init_idx       <= '0;
			col            <= '0;
			row            <= '0;
			out_frame_done <= 1'b0;
		end else begin
			out_frame_done <= 1'b0;
			case (state)
				PanelReset: begin
					rst_cnt <= rst_cnt + 1'b1;
					if (rst_cnt == RST_W'(`DISP_RST_CYCLES - 1)) begin
						state <= SendInit;
					end
				end
				SendInit: begin
					if (word_take) begin
						init_idx <= init_idx + 1'b1;
						if (init_idx == INIT_W'(`DISP_INIT_BYTES - 1)) begin
							state <= SendHigh;
						end
					end
				end
				SendHigh: begin
					if (word_take) begin
						state <= SendLow;
					end
				end
				SendLow: begin
					if (word_take) begin
						state <= SendHigh;
						// raster position, wraps at end of frame
						if (last_col) begin
							col <= '0;
							if (last_row) begin
								row            <= '0;
								out_frame_done <= 1'b1;
							end else begin
								row <= row + 1'b1;
							end
						end else begin
							col <= col + 1'b1;
						end
					end
				end
				default: begin
					state <= PanelReset;
				end
			endcase
		end
	end

	a_col_range: assert property (@(posedge in_clk) disable iff (in_rst)
		col < COL_W'(`DISP_SCREEN_WIDTH));
	a_row_range: assert property (@(posedge in_clk) disable iff (in_rst)
		row < ROW_W'(`DISP_SCREEN_HEIGHT));

endmodule

/* source/serial_display_top.sv */
/*
 * serial display controller, no chip select and no read back
 * the pixel source keeps its own raster count, pixels arrive in raster order
 */
`include "display_macros.svh"

module serial_display_top
	import display_pkg::*;
(
	input  logic   in_clk,
	input  logic   in_rst,

	// pixel stream
	input  logic   in_pix_valid,
	output logic   in_pix_ready,
	input  pixel_t in_pix,

	// panel
	output logic   out_disp_rst,
	output logic   out_sclk,
	output logic   out_sdata,
	output logic   out_dc,
	output logic   out_frame_done
);

	// buffered pixels into the sequencer
	logic         pix_valid;
	logic         pix_ready;
	pixel_t       pix_data;

	// sequencer into the word buffer
	logic         seq_valid;
	logic         seq_ready;
	serial_word_t seq_word;

	// word buffer into the shifter
	logic         sh_valid;
	logic         sh_ready;
	serial_word_t sh_word;

	stream_buffer #(
		.payload_t (pixel_t),
		.DEPTH     (`DISP_FIFO_DEPTH)
	) pix_buf (
		.in_clk    (in_clk),
		.in_rst    (in_rst),
		.in_valid  (in_pix_valid),
		.in_ready  (in_pix_ready),
		.in_data   (in_pix),
		.out_valid (pix_valid),
		.out_ready (pix_ready),
		.out_data  (pix_data)
	);

	display_sequencer seq (
		.in_clk         (in_clk),
		.in_rst         (in_rst),
		.in_pix_valid   (pix_valid),
		.in_pix_ready   (pix_ready),
		.in_pix         (pix_data),
		.out_word_valid (seq_valid),
		.in_word_ready  (seq_ready),
		.out_word       (seq_word),
		.out_disp_rst   (out_disp_rst),
		.out_frame_done (out_frame_done)
	);

	stream_buffer #(
		.payload_t (serial_word_t),
		.DEPTH     (`DISP_FIFO_DEPTH)
	) word_buf (
		.in_clk    (in_clk),
		.in_rst    (in_rst),
		.in_valid  (seq_valid),
		.in_ready  (seq_ready),
		.in_data   (seq_word),
		.out_valid (sh_valid),
		.out_ready (sh_ready),
		.out_data  (sh_word)
	);

	serial_shifter shifter (
		.in_clk    (in_clk),
		.in_rst    (in_rst),
		.in_valid  (sh_valid),
		.in_ready  (sh_ready),
		.in_word   (sh_word),
		.out_sclk  (out_sclk),
		.out_sdata (out_sdata),
		.out_dc    (out_dc)
	);

endmodule

/* source/serial_shifter.sv */
/*
 * shifts one serial word MSB first, serial clock idles high
 * a word takes 2 x DISP_SERIAL_BITS x DISP_CLK_DIV cycles up to its last rising edge
 * data changes only on the falling serial clock edge
 */
`include "display_macros.svh"

module serial_shifter
	import display_pkg::*;
(
	input  logic         in_clk,
	input  logic         in_rst,

	// word stream
	input  logic         in_valid,
	output logic         in_ready,
	input  serial_word_t in_word,

	// serial line
	output logic         out_sclk,
	output logic         out_sdata,
	output logic         out_dc
);

	localparam int DIV_W = (`DISP_CLK_DIV > 1) ? $clog2(`DISP_CLK_DIV) : 1;
	localparam int BIT_W = (`DISP_SERIAL_BITS > 1) ? $clog2(`DISP_SERIAL_BITS) : 1;

	logic                         busy;
	logic [DIV_W-1:0]             div_cnt;
	logic [BIT_W-1:0]             bit_cnt;
	logic [`DISP_SERIAL_BITS-1:0] shift_reg;
	logic                         half_tick;
	logic                         last_bit;

	// accept only between words
	assign in_ready = ~busy;

	// end of a serial clock half period
	assign half_tick = busy && (div_cnt == DIV_W'(`DISP_CLK_DIV - 1));
	assign last_bit  = (bit_cnt == BIT_W'(`DISP_SERIAL_BITS - 1));

	// ------------------------------------------------------------
	// shift engine
	// ------------------------------------------------------------
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			busy      <= 1'b0;
			div_cnt   <= '0;
			bit_cnt   <= '0;
			shift_reg <= '0;
			out_sclk  <= 1'b1;
			out_sdata <= 1'b0;
			out_dc    <= 1'b0;
		end else if (!busy) begin
			if (in_valid) begin
				busy      <= 1'b1;
				div_cnt   <= '0;
				bit_cnt   <= '0;
				shift_reg <= in_word.data;
				out_dc    <= in_word.dc;
			end
		end else begin
			div_cnt <= div_cnt + 1'b1;
			if (half_tick) begin
				div_cnt  <= '0;
				out_sclk <= ~out_sclk;
				if (out_sclk) begin
					// falling edge puts out the next bit
					out_sdata <= shift_reg[`DISP_SERIAL_BITS-1];
					shift_reg <= shift_reg << 1;
				end else begin
					// rising edge, panel samples here
					bit_cnt <= bit_cnt + 1'b1;
					if (last_bit) begin
						busy <= 1'b0;
					end
				end
			end
		end
	end

	// panel samples on the rising edge, data must hold while clock is high
	a_data_stable: assert property (@(posedge in_clk) disable iff (in_rst)
		busy && out_sclk |-> $stable(out_sdata));

endmodule

/* source/stream_buffer.sv */
/*
 * valid/ready FIFO, payload type set by parameter
 * output valid follows a write into an empty buffer by one cycle
 */
`include "display_macros.svh"

module stream_buffer
	import display_pkg::*;
#(
	parameter type payload_t = pixel_t,
	parameter int  DEPTH     = `DISP_FIFO_DEPTH
) (
	input  logic     in_clk,
	input  logic     in_rst,

	// write side
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,

	// read side
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// wrap for depths that are not a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign in_ready  = (count != CNT_W'(DEPTH));
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr];
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	// storage
	always_ff @(posedge in_clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	// pointers and occupancy
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// a stalled word stays offered and unchanged
	a_hold_stalled: assert property (@(posedge in_clk) disable iff (in_rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule
